// File: Bender.yml
package:
  name: fwd_updater

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fwd_pkg.sv
      - fwd_history.sv
      - fwd_merge_stage.sv
      - fwd_updater_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fwd_updater_props.sv
      - fwd_updater_tb.sv

// File: filelist.f
+incdir+.
fwd_pkg.sv
fwd_history.sv
fwd_merge_stage.sv
fwd_updater_top.sv
fwd_updater_props.sv
fwd_updater_tb.sv

// File: fwd_history.sv
`default_nettype none

module fwd_history #(
    parameter int DEPTH = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clk_en_i,
    input  logic [fwd_pkg::FWD_REC_W-1:0] rec_i,
    output logic [fwd_pkg::FWD_REC_W-1:0] rec_o
);

    import fwd_pkg::*;

    // hist_q[0] holds the newest record, hist_q[DEPTH-1] the oldest
    logic [FWD_REC_W-1:0] hist_q [DEPTH-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            // cleared records have we low, so nothing hits
            for (int i = 0; i < DEPTH; i++) begin
                hist_q[i] <= '0;
            end
        end else if (clk_en_i) begin
            hist_q[0] <= rec_i;
            for (int i = 1; i < DEPTH; i++) begin
                hist_q[i] <= hist_q[i-1];
            end
        end
    end

    // record of enabled cycle n shows up in enabled cycle n+DEPTH
    assign rec_o = hist_q[DEPTH-1];

endmodule

`default_nettype wire

// File: fwd_macros.svh
`ifndef FWD_MACROS_SVH
`define FWD_MACROS_SVH

// number of hash tables served in parallel
`define FWD_NUM_TABLES 4

// hash address width, same for every table
`define FWD_ADR_W 4

// key stored per entry
`define FWD_KEY_W 8

// payload stored per entry
`define FWD_DATA_W 16

// write cycles the memory read misses
// also the number of merge stages per table
`define FWD_CYCLES 2

`endif

// File: fwd_merge_stage.sv
`default_nettype none

`include "fwd_macros.svh"

module fwd_merge_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clk_en_i,
    input  logic [`FWD_ADR_W-1:0]         adr_i,
    input  logic [`FWD_KEY_W-1:0]         key_i,
    input  logic [`FWD_DATA_W-1:0]        data_i,
    input  logic                          valid_i,
    input  logic [fwd_pkg::FWD_REC_W-1:0] rec_i,
    output logic [`FWD_ADR_W-1:0]         adr_o,
    output logic [`FWD_KEY_W-1:0]         key_o,
    output logic [`FWD_DATA_W-1:0]        data_o,
    output logic                          valid_o
);

    import fwd_pkg::*;

    // fields of the forwarded write
    logic [`FWD_KEY_W-1:0]  rec_key;
    logic [`FWD_DATA_W-1:0] rec_data;
    logic                   rec_valid;

    logic                   hit;

    // merged entry before the register
    logic [`FWD_KEY_W-1:0]  key_d;
    logic [`FWD_DATA_W-1:0] data_d;
    logic                   valid_d;

    assign rec_key   = rec_i[FWD_KEY_LSB +: `FWD_KEY_W];
    assign rec_data  = rec_i[FWD_DATA_LSB +: `FWD_DATA_W];
    assign rec_valid = rec_i[FWD_VALID_BIT];

    // only a write that really reached the memory counts
    assign hit = fwd_addr_hit(rec_i, adr_i);

    always_comb begin
        if (hit) begin
            key_d   = rec_key;
            data_d  = rec_data;
            // a write with valid low deletes the entry
            valid_d = rec_valid;
        end else begin
            key_d   = key_i;
            data_d  = data_i;
            valid_d = valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            adr_o   <= '0;
            key_o   <= '0;
            data_o  <= '0;
            valid_o <= 1'b0;
        end else if (clk_en_i) begin
            // address moves along so the next stage compares the same slot
            adr_o   <= adr_i;
            key_o   <= key_d;
            data_o  <= data_d;
            valid_o <= valid_d;
        end
    end

endmodule

`default_nettype wire

// File: fwd_pkg.sv
`default_nettype none

`include "fwd_macros.svh"

package fwd_pkg;

    // write record layout, msb first: adr, we, valid, key, data
    localparam int FWD_DATA_LSB  = 0;
    localparam int FWD_KEY_LSB   = FWD_DATA_LSB + `FWD_DATA_W;
    localparam int FWD_VALID_BIT = FWD_KEY_LSB + `FWD_KEY_W;
    localparam int FWD_WE_BIT    = FWD_VALID_BIT + 1;
    localparam int FWD_ADR_LSB   = FWD_WE_BIT + 1;
    localparam int FWD_REC_W     = FWD_ADR_LSB + `FWD_ADR_W;

    // build one write record from its fields
    function automatic logic [FWD_REC_W-1:0] fwd_pack_rec(
        input logic [`FWD_ADR_W-1:0]  adr,
        input logic                   we,
        input logic                   valid,
        input logic [`FWD_KEY_W-1:0]  key,
        input logic [`FWD_DATA_W-1:0] data
    );
        return {adr, we, valid, key, data};
    endfunction

    // record wrote the memory at the entry address
    function automatic logic fwd_addr_hit(
        input logic [FWD_REC_W-1:0]  rec,
        input logic [`FWD_ADR_W-1:0] adr
    );
        logic [`FWD_ADR_W-1:0] rec_adr;
        rec_adr = rec[FWD_ADR_LSB +: `FWD_ADR_W];
        return rec[FWD_WE_BIT] && (rec_adr == adr);
    endfunction

endpackage

`default_nettype wire

// File: fwd_updater_props.sv
`default_nettype none

`include "fwd_macros.svh"

module fwd_updater_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   clk_en_i,
    input logic                   rd_valid_i  [`FWD_NUM_TABLES-1:0],
    input logic                   wr_valid_i  [`FWD_NUM_TABLES-1:0],
    input logic                   wr_en_i     [`FWD_NUM_TABLES-1:0],
    input logic [`FWD_KEY_W-1:0]  fix_key_i   [`FWD_NUM_TABLES-1:0],
    input logic [`FWD_DATA_W-1:0] fix_data_i  [`FWD_NUM_TABLES-1:0],
    input logic                   fix_valid_i [`FWD_NUM_TABLES-1:0]
);

    // a valid source is visible at the output for at most this many enabled edges
    localparam int QUIET = 2 * `FWD_CYCLES;

    int unsigned fail_cnt = 0;

    // enabled cycles since the last valid read or valid write
    int unsigned quiet_cnt [`FWD_NUM_TABLES-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < `FWD_NUM_TABLES; t++) begin
                quiet_cnt[t] <= QUIET;
            end
        end else if (clk_en_i) begin
            for (int t = 0; t < `FWD_NUM_TABLES; t++) begin
                if (rd_valid_i[t] || (wr_en_i[t] && wr_valid_i[t])) begin
                    quiet_cnt[t] <= 0;
                end else if (quiet_cnt[t] < QUIET) begin
                    quiet_cnt[t] <= quiet_cnt[t] + 1;
                end
            end
        end
    end

    for (genvar t = 0; t < `FWD_NUM_TABLES; t++) begin : g_table
        a_valid_low_after_reset: assert property (
            @(posedge clk) reset |=> !fix_valid_i[t]
        ) else begin
            fail_cnt++;
            $error("fix_valid_o[%0d] high in the cycle after reset", t);
        end

        // stalled cycle keeps every output register
        a_hold_on_stall: assert property (
            @(posedge clk) (!reset && !clk_en_i) |=>
                ($stable(fix_key_i[t]) && $stable(fix_data_i[t]) && $stable(fix_valid_i[t]))
        ) else begin
            fail_cnt++;
            $error("outputs of table %0d changed during a stall", t);
        end

        a_valid_has_source: assert property (
            @(posedge clk) disable iff (reset)
                (quiet_cnt[t] >= QUIET) |-> !fix_valid_i[t]
        ) else begin
            fail_cnt++;
            $error("fix_valid_o[%0d] high without a valid read or write", t);
        end
    end

endmodule

bind fwd_updater_top fwd_updater_props u_fwd_updater_props (
    .clk         (clk),
    .reset       (reset),
    .clk_en_i    (clk_en_i),
    .rd_valid_i  (rd_valid_i),
    .wr_valid_i  (wr_valid_i),
    .wr_en_i     (wr_en_i),
    .fix_key_i   (fix_key_o),
    .fix_data_i  (fix_data_o),
    .fix_valid_i (fix_valid_o)
);

`default_nettype wire

// File: fwd_updater_tb.sv
`default_nettype none

`include "fwd_macros.svh"

module fwd_updater_tb;

    localparam int NT         = `FWD_NUM_TABLES;
    localparam int ENT_W      = 1 + `FWD_KEY_W + `FWD_DATA_W;
    localparam int NUM_CYCLES = 2000;
    localparam int CLK_PERIOD = 20;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   clk_en;

    logic [`FWD_ADR_W-1:0]  rd_adr    [NT-1:0];
    logic [`FWD_KEY_W-1:0]  rd_key    [NT-1:0];
    logic [`FWD_DATA_W-1:0] rd_data   [NT-1:0];
    logic                   rd_valid  [NT-1:0];

    logic [`FWD_ADR_W-1:0]  wr_adr    [NT-1:0];
    logic [`FWD_KEY_W-1:0]  wr_key    [NT-1:0];
    logic [`FWD_DATA_W-1:0] wr_data   [NT-1:0];
    logic                   wr_valid  [NT-1:0];
    logic                   wr_en     [NT-1:0];

    logic [`FWD_KEY_W-1:0]  fix_key   [NT-1:0];
    logic [`FWD_DATA_W-1:0] fix_data  [NT-1:0];
    logic                   fix_valid [NT-1:0];

    // model write history per table, index 0 is the oldest enabled write
    logic [`FWD_ADR_W-1:0]  hist_adr  [NT-1:0][$];
    logic                   hist_we   [NT-1:0][$];
    logic [ENT_W-1:0]       hist_ent  [NT-1:0][$];

    // merged reads still inside the pipeline, entry word is {valid, key, data}
    logic [ENT_W-1:0]       pend_ent  [NT-1:0][$];
    logic [ENT_W-1:0]       exp_ent   [NT-1:0];

    integer                 seed = 23;

    fwd_updater_top u_fwd_updater_top (
        .clk         (clk),
        .reset       (reset),
        .clk_en_i    (clk_en),
        .rd_adr_i    (rd_adr),
        .rd_key_i    (rd_key),
        .rd_data_i   (rd_data),
        .rd_valid_i  (rd_valid),
        .wr_adr_i    (wr_adr),
        .wr_key_i    (wr_key),
        .wr_data_i   (wr_data),
        .wr_valid_i  (wr_valid),
        .wr_en_i     (wr_en),
        .fix_key_o   (fix_key),
        .fix_data_o  (fix_data),
        .fix_valid_o (fix_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int pick_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s actual=0x%0h expected=0x%0h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    // any assertion error in the bound checker ends the run right away
    task automatic check_bound_asserts();
        if (u_fwd_updater_top.u_fwd_updater_props.fail_cnt != 0) begin
            $display("an assertion in the bound checker failed at time %0t", $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%0d assertion failures in the bound checker",
                   u_fwd_updater_top.u_fwd_updater_props.fail_cnt);
        end
    endtask

    task automatic init_inputs();
        clk_en = 1'b0;
        for (int t = 0; t < NT; t++) begin
            rd_adr[t]   = '0;
            rd_key[t]   = '0;
            rd_data[t]  = '0;
            rd_valid[t] = 1'b0;
            wr_adr[t]   = '0;
            wr_key[t]   = '0;
            wr_data[t]  = '0;
            wr_valid[t] = 1'b0;
            wr_en[t]    = 1'b0;
        end
    endtask

    // history and pipeline start out as cleared registers
    task automatic model_reset();
        for (int t = 0; t < NT; t++) begin
            hist_adr[t].delete();
            hist_we[t].delete();
            hist_ent[t].delete();
            pend_ent[t].delete();
            for (int i = 0; i < `FWD_CYCLES; i++) begin
                hist_adr[t].push_back('0);
                hist_we[t].push_back(1'b0);
                hist_ent[t].push_back('0);
            end
            for (int i = 0; i < `FWD_CYCLES - 1; i++) begin
                pend_ent[t].push_back('0);
            end
            exp_ent[t] = '0;
        end
    endtask

    // called at a rising edge with the inputs the DUT just sampled
    task automatic model_step();
        logic [ENT_W-1:0] ent;
        if (clk_en) begin
            for (int t = 0; t < NT; t++) begin
                ent = {rd_valid[t], rd_key[t], rd_data[t]};
                // oldest write first, so the newest hit is what remains
                for (int i = 0; i < `FWD_CYCLES; i++) begin
                    if (hist_we[t][i] && (hist_adr[t][i] == rd_adr[t])) begin
                        ent = hist_ent[t][i];
                    end
                end
                pend_ent[t].push_back(ent);
                exp_ent[t] = pend_ent[t].pop_front();

                hist_adr[t].push_back(wr_adr[t]);
                hist_we[t].push_back(wr_en[t]);
                hist_ent[t].push_back({wr_valid[t], wr_key[t], wr_data[t]});
                void'(hist_adr[t].pop_front());
                void'(hist_we[t].pop_front());
                void'(hist_ent[t].pop_front());
            end
        end
    endtask

    task automatic check_outputs();
        for (int t = 0; t < NT; t++) begin
            check_value($sformatf("fix_valid_o[%0d]", t), 32'(fix_valid[t]),
                        32'(exp_ent[t][ENT_W-1]));
            check_value($sformatf("fix_key_o[%0d]", t), 32'(fix_key[t]),
                        32'(exp_ent[t][`FWD_DATA_W +: `FWD_KEY_W]));
            check_value($sformatf("fix_data_o[%0d]", t), 32'(fix_data[t]),
                        32'(exp_ent[t][`FWD_DATA_W-1:0]));
        end
    endtask

    // small address pool keeps reads and writes colliding often
    task automatic drive_random();
        clk_en = (pick_below(10) < 8);
        for (int t = 0; t < NT; t++) begin
            rd_adr[t]   = `FWD_ADR_W'(pick_below(4));
            rd_key[t]   = `FWD_KEY_W'($random(seed));
            rd_data[t]  = `FWD_DATA_W'($random(seed));
            rd_valid[t] = (pick_below(2) != 0);
            wr_adr[t]   = `FWD_ADR_W'(pick_below(4));
            wr_key[t]   = `FWD_KEY_W'($random(seed));
            wr_data[t]  = `FWD_DATA_W'($random(seed));
            // some writes delete the entry
            wr_valid[t] = (pick_below(4) != 0);
            wr_en[t]    = (pick_below(2) != 0);
        end
    endtask

    initial begin
        reset = 1'b1;
        init_inputs();
        model_reset();
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        // nothing has passed through yet, all outputs cleared
        check_outputs();
        check_bound_asserts();

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_random();
            @(posedge clk);
            model_step();
            #1;
            check_outputs();
            check_bound_asserts();
            #1;
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    // run length plus slack for reset
    initial begin
        #((NUM_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired: the run did not finish in %0d cycles", NUM_CYCLES + 100);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped by the watchdog");
    end

endmodule

`default_nettype wire

// File: fwd_updater_top.sv
`default_nettype none

`include "fwd_macros.svh"

module fwd_updater_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clk_en_i,

    // entry returned by each table memory
    input  logic [`FWD_ADR_W-1:0]  rd_adr_i   [`FWD_NUM_TABLES-1:0],
    input  logic [`FWD_KEY_W-1:0]  rd_key_i   [`FWD_NUM_TABLES-1:0],
    input  logic [`FWD_DATA_W-1:0] rd_data_i  [`FWD_NUM_TABLES-1:0],
    input  logic                   rd_valid_i [`FWD_NUM_TABLES-1:0],

    // write issued to each table memory this cycle
    input  logic [`FWD_ADR_W-1:0]  wr_adr_i   [`FWD_NUM_TABLES-1:0],
    input  logic [`FWD_KEY_W-1:0]  wr_key_i   [`FWD_NUM_TABLES-1:0],
    input  logic [`FWD_DATA_W-1:0] wr_data_i  [`FWD_NUM_TABLES-1:0],
    input  logic                   wr_valid_i [`FWD_NUM_TABLES-1:0],
    input  logic                   wr_en_i    [`FWD_NUM_TABLES-1:0],

    output logic [`FWD_KEY_W-1:0]  fix_key_o   [`FWD_NUM_TABLES-1:0],
    output logic [`FWD_DATA_W-1:0] fix_data_o  [`FWD_NUM_TABLES-1:0],
    output logic                   fix_valid_o [`FWD_NUM_TABLES-1:0]
);

    import fwd_pkg::*;

    // write record entering and leaving each history
    logic [FWD_REC_W-1:0]   wr_rec  [`FWD_NUM_TABLES-1:0];
    logic [FWD_REC_W-1:0]   fwd_rec [`FWD_NUM_TABLES-1:0];

    // merge chain, index 0 is the raw read, index s+1 leaves stage s
    logic [`FWD_KEY_W-1:0]  key_c   [`FWD_NUM_TABLES-1:0][`FWD_CYCLES:0];
    logic [`FWD_DATA_W-1:0] data_c  [`FWD_NUM_TABLES-1:0][`FWD_CYCLES:0];
    logic                   valid_c [`FWD_NUM_TABLES-1:0][`FWD_CYCLES:0];

    // address is not needed after the last stage
    logic [`FWD_ADR_W-1:0]  adr_c   [`FWD_NUM_TABLES-1:0][`FWD_CYCLES-1:0];

    genvar t, s;

    generate
        for (t = 0; t < `FWD_NUM_TABLES; t++) begin : g_table
            assign wr_rec[t] = fwd_pack_rec(wr_adr_i[t], wr_en_i[t], wr_valid_i[t],
                                            wr_key_i[t], wr_data_i[t]);

            fwd_history #(
                .DEPTH (`FWD_CYCLES)
            ) u_fwd_history (
                .clk      (clk),
                .reset    (reset),
                .clk_en_i (clk_en_i),
                .rec_i    (wr_rec[t]),
                .rec_o    (fwd_rec[t])
            );

            assign adr_c[t][0]   = rd_adr_i[t];
            assign key_c[t][0]   = rd_key_i[t];
            assign data_c[t][0]  = rd_data_i[t];
            assign valid_c[t][0] = rd_valid_i[t];

            // every stage sees the write made FWD_CYCLES enabled cycles ago,
            // so an entry in stage s meets the write of cycle n-FWD_CYCLES+s
            for (s = 0; s < `FWD_CYCLES; s++) begin : g_stage
                if (s < `FWD_CYCLES - 1) begin : g_mid
                    fwd_merge_stage u_fwd_merge_stage (
                        .clk      (clk),
                        .reset    (reset),
                        .clk_en_i (clk_en_i),
                        .adr_i    (adr_c[t][s]),
                        .key_i    (key_c[t][s]),
                        .data_i   (data_c[t][s]),
                        .valid_i  (valid_c[t][s]),
                        .rec_i    (fwd_rec[t]),
                        .adr_o    (adr_c[t][s+1]),
                        .key_o    (key_c[t][s+1]),
                        .data_o   (data_c[t][s+1]),
                        .valid_o  (valid_c[t][s+1])
                    );
                end else begin : g_last
                    // newest write applied last and wins
                    fwd_merge_stage u_fwd_merge_stage (
                        .clk      (clk),
                        .reset    (reset),
                        .clk_en_i (clk_en_i),
                        .adr_i    (adr_c[t][s]),
                        .key_i    (key_c[t][s]),
                        .data_i   (data_c[t][s]),
                        .valid_i  (valid_c[t][s]),
                        .rec_i    (fwd_rec[t]),
                        .adr_o    (),
                        .key_o    (key_c[t][s+1]),
                        .data_o   (data_c[t][s+1]),
                        .valid_o  (valid_c[t][s+1])
                    );
                end
            end

            // last stage register drives the outputs directly
            assign fix_key_o[t]   = key_c[t][`FWD_CYCLES];
            assign fix_data_o[t]  = data_c[t][`FWD_CYCLES];
            assign fix_valid_o[t] = valid_c[t][`FWD_CYCLES];
        end
    endgenerate

endmodule

`default_nettype wire
